// ==== project.f ====
source/eth_pkg.sv
source/rx_buffer_pkg.sv
source/packet_fifo_if.sv
source/rx_ingest.sv
source/packet_fifo.sv
source/meta_fifo.sv
source/frame_forwarder.sv
source/rx_fifo.sv
tests/rx_fifo_sva.sv
tests/tb_rx_fifo.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --assert -j 0
TOP = tb_rx_fifo
FILELIST = project.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== tests/tb_rx_fifo.sv ====
module tb_rx_fifo
	import eth_pkg::*;
	import rx_buffer_pkg::*;
();

	localparam int TIMEOUT = 3000;

	logic fabric_clk;
	logic rst_n;
	logic in_start;
	mac_addr_t in_dst_mac;
	mac_addr_t in_src_mac;
	ethertype_t in_ethertype;
	logic in_has_tag;
	vlan_id_t in_tag_vlan;
	logic in_valid;
	half_word_t in_data;
	byte_count_t in_bytes;
	logic in_commit;
	logic in_drop;
	logic has_port_vlan;
	vlan_id_t port_vlan_id;
	logic native_vlan_allowed;
	logic q_queued;
	logic q_drop_fifo;
	logic q_drop_vlan;
	logic q_drop_runt;
	logic q_drop_jumbo;
	logic frame_valid;
	mac_addr_t frame_dst_mac;
	mac_addr_t frame_src_mac;
	vlan_id_t frame_vlan;
	logic fwd_en;
	logic fwd_valid;
	byte_count_t fwd_bytes;
	fifo_word_t fwd_data;
	logic fabric_pop;

	// Random source state
	logic [31:0] lfsr_state;
	// Payload bytes of every frame sent back to back
	logic [7:0] pool [16384];
	int pool_top;
	// Stored frames indexed in send order
	mac_addr_t f_dst [128];
	mac_addr_t f_src [128];
	ethertype_t f_et [128];
	vlan_id_t f_vlan [128];
	int f_len [128];
	int f_base [128];
	int nframes;
	// Frames that got q_queued with the oldest first
	int exp_q [$];
	// Frame on the stream and word count at its start
	int cur_frame;
	int cur_start;
	int words_seen;
	int n_queued;
	int n_fifo;
	int n_vlan;
	int n_runt;
	int n_jumbo;
	string test_name;

	rx_fifo u_dut (.*);

	initial begin
		fabric_clk = 1'b0;
		forever #2 fabric_clk = ~fabric_clk;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		logic fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input logic [63:0] exp_v,
			input logic [63:0] act_v);
		if (exp_v !== act_v) begin
			stop_run($sformatf("[ERROR] %s: %s expected %0h actual %0h",
				test_name, what, exp_v, act_v));
		end
	endtask

	function automatic int total_pulses();
		return n_queued + n_fifo + n_vlan + n_runt + n_jumbo;
	endfunction

	function automatic int word_total(input int f);
		return (f_len[f] + ETH_HEADER_BYTES + 7) / 8;
	endfunction

	// Byte i of the rebuilt frame or zero past its end
	function automatic logic [7:0] stream_byte(input int f, input int i);
		if (i < 6) begin
			return f_dst[f][8*(5-i) +: 8];
		end else if (i < 12) begin
			return f_src[f][8*(11-i) +: 8];
		end else if (i < 14) begin
			return f_et[f][8*(13-i) +: 8];
		end else if (i < 14 + f_len[f]) begin
			return pool[f_base[f] + i - 14];
		end
		return 8'h00;
	endfunction

	// Reference word w of frame f with the byte count on top
	function automatic logic [67:0] expected_word(input int f, input int w);
		int nb;
		logic [63:0] d;
		nb = f_len[f] + ETH_HEADER_BYTES - 8 * w;
		if (nb > 8) begin
			nb = 8;
		end
		for (int b = 0; b < 8; b++) begin
			d[8*(7-b) +: 8] = stream_byte(f, 8 * w + b);
		end
		return {4'(nb), d};
	endfunction

	//////////////////////////////
	// Pulse counting and stream compare
	//////////////////////////////

	always @(posedge fabric_clk) begin
		logic [67:0] exp_w;
		int idx;
		if (rst_n) begin
			if (q_queued) n_queued <= n_queued + 1;
			if (q_drop_fifo) n_fifo <= n_fifo + 1;
			if (q_drop_vlan) n_vlan <= n_vlan + 1;
			if (q_drop_runt) n_runt <= n_runt + 1;
			if (q_drop_jumbo) n_jumbo <= n_jumbo + 1;
			if (fwd_valid) begin
				idx = words_seen - cur_start;
				if (idx >= word_total(cur_frame)) begin
					check_value("stream length", 64'(word_total(cur_frame)), 64'(idx + 1));
				end
				exp_w = expected_word(cur_frame, idx);
				check_value("fwd_bytes", 64'(exp_w[67:64]), 64'(fwd_bytes));
				check_value("fwd_data", exp_w[63:0], fwd_data);
				words_seen <= words_seen + 1;
			end
		end
	end

	//////////////////////////////
	// Frame input and fabric side
	//////////////////////////////

	// Result 0 none, 1 queued, 2 fifo, 3 vlan, 4 runt, 5 jumbo
	task automatic send_frame(input logic has_tag, input vlan_id_t tag, input int len,
			input int drop_at, output int result);
		int f;
		int nb;
		int cycles;
		int q0;
		int f0;
		int v0;
		int r0;
		int j0;
		logic [31:0] word;
		logic [31:0] rnd;
		f = nframes;
		nframes++;
		rnd = take_bits(32);
		f_dst[f] = {16'h0200, rnd};
		rnd = take_bits(32);
		f_src[f] = {16'h0a00, rnd};
		f_et[f] = 16'h0800;
		f_vlan[f] = has_tag ? tag : port_vlan_id;
		f_len[f] = len;
		f_base[f] = pool_top;
		for (int i = 0; i < len; i++) begin
			rnd = take_bits(8);
			pool[pool_top + i] = rnd[7:0];
		end
		pool_top += len;
		q0 = n_queued;
		f0 = n_fifo;
		v0 = n_vlan;
		r0 = n_runt;
		j0 = n_jumbo;
		in_start <= 1'b1;
		in_dst_mac <= f_dst[f];
		in_src_mac <= f_src[f];
		in_ethertype <= f_et[f];
		in_has_tag <= has_tag;
		in_tag_vlan <= tag;
		@(posedge fabric_clk);
		in_start <= 1'b0;
		for (int k = 0; k < (len + 3) / 4; k++) begin
			// Occasional idle cycle inside the payload
			if (k % 7 == 5) begin
				in_valid <= 1'b0;
				@(posedge fabric_clk);
			end
			if (k == drop_at) begin
				break;
			end
			nb = (len - 4 * k > 4) ? 4 : len - 4 * k;
			// Unused low bytes carry junk
			word = take_bits(32);
			for (int b = 0; b < nb; b++) begin
				word[8*(3-b) +: 8] = pool[f_base[f] + 4 * k + b];
			end
			in_valid <= 1'b1;
			in_data <= word;
			in_bytes <= byte_count_t'(nb);
			@(posedge fabric_clk);
		end
		in_valid <= 1'b0;
		result = 0;
		if (drop_at >= 0) begin
			in_drop <= 1'b1;
			@(posedge fabric_clk);
			in_drop <= 1'b0;
			repeat (6) @(posedge fabric_clk);
			check_value("pulses after in_drop", 64'(q0 + f0 + v0 + r0 + j0),
				64'(total_pulses()));
		end else begin
			in_commit <= 1'b1;
			@(posedge fabric_clk);
			in_commit <= 1'b0;
			cycles = 0;
			while (n_queued == q0 && n_fifo == f0 && n_vlan == v0 && n_runt == r0
					&& n_jumbo == j0) begin
				@(posedge fabric_clk);
				cycles++;
				if (cycles > TIMEOUT) begin
					stop_run("Timed out waiting for an event pulse after in_commit");
				end
			end
			if (n_queued != q0) result = 1;
			else if (n_fifo != f0) result = 2;
			else if (n_vlan != v0) result = 3;
			else if (n_runt != r0) result = 4;
			else result = 5;
			// Required idle gap that also catches a second pulse
			repeat (3) @(posedge fabric_clk);
			check_value("pulse count", 64'(q0 + f0 + v0 + r0 + j0 + 1),
				64'(total_pulses()));
		end
		if (result == 1) begin
			exp_q.push_back(f);
		end
	endtask

	// Check the head frame, stream it and pop it
	task automatic forward_head();
		int f;
		int cycles;
		f = exp_q.pop_front();
		cycles = 0;
		do begin
			@(posedge fabric_clk);
			cycles++;
			if (cycles > TIMEOUT) begin
				stop_run("Timed out waiting for frame_valid");
			end
		end while (frame_valid !== 1'b1);
		check_value("frame_dst_mac", 64'(f_dst[f]), 64'(frame_dst_mac));
		check_value("frame_src_mac", 64'(f_src[f]), 64'(frame_src_mac));
		check_value("frame_vlan", 64'(f_vlan[f]), 64'(frame_vlan));
		cur_frame = f;
		cur_start = words_seen;
		fwd_en <= 1'b1;
		@(posedge fabric_clk);
		fwd_en <= 1'b0;
		cycles = 0;
		while (words_seen != cur_start + word_total(f)) begin
			@(posedge fabric_clk);
			cycles++;
			if (cycles > TIMEOUT) begin
				stop_run("Timed out waiting for the end of the output stream");
			end
		end
		fabric_pop <= 1'b1;
		@(posedge fabric_clk);
		fabric_pop <= 1'b0;
		cycles = 0;
		do begin
			@(posedge fabric_clk);
			cycles++;
			if (cycles > TIMEOUT) begin
				stop_run("frame_valid did not fall after the pop");
			end
		end while (frame_valid !== 1'b0);
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		int r;
		lfsr_state = 32'h8ad6_9b2f;
		pool_top = 0;
		nframes = 0;
		cur_frame = 0;
		cur_start = 0;
		words_seen = 0;
		n_queued = 0;
		n_fifo = 0;
		n_vlan = 0;
		n_runt = 0;
		n_jumbo = 0;
		rst_n = 1'b0;
		in_start = 1'b0;
		in_dst_mac = '0;
		in_src_mac = '0;
		in_ethertype = '0;
		in_has_tag = 1'b0;
		in_tag_vlan = '0;
		in_valid = 1'b0;
		in_data = '0;
		in_bytes = '0;
		in_commit = 1'b0;
		in_drop = 1'b0;
		has_port_vlan = 1'b1;
		port_vlan_id = 12'h05a;
		native_vlan_allowed = 1'b0;
		fwd_en = 1'b0;
		fabric_pop = 1'b0;
		repeat (4) @(posedge fabric_clk);
		rst_n <= 1'b1;
		@(posedge fabric_clk);
		test_name = "reset";
		check_value("frame_valid", 64'(0), 64'(frame_valid));
		check_value("fwd_valid", 64'(0), 64'(fwd_valid));
		check_value("pulses", 64'(0),
			64'({q_queued, q_drop_fifo, q_drop_vlan, q_drop_runt, q_drop_jumbo}));

		// Untagged frame on an access port joins the port VLAN
		test_name = "access port";
		send_frame(1'b0, 12'h000, 64, -1, r);
		check_value("result", 64'(1), 64'(r));
		forward_head();

		// Trunk keeps tags and rejects untagged traffic
		test_name = "trunk port";
		has_port_vlan <= 1'b0;
		@(posedge fabric_clk);
		send_frame(1'b1, 12'h123, 80, -1, r);
		check_value("tagged result", 64'(1), 64'(r));
		forward_head();
		send_frame(1'b0, 12'h000, 60, -1, r);
		check_value("untagged result", 64'(3), 64'(r));
		test_name = "native vlan";
		has_port_vlan <= 1'b1;
		@(posedge fabric_clk);
		send_frame(1'b1, 12'h321, 70, -1, r);
		check_value("tag without native", 64'(3), 64'(r));
		native_vlan_allowed <= 1'b1;
		@(posedge fabric_clk);
		send_frame(1'b1, 12'h321, 70, -1, r);
		check_value("tag with native", 64'(1), 64'(r));
		forward_head();

		test_name = "length limits";
		send_frame(1'b0, 12'h000, 20, -1, r);
		check_value("runt result", 64'(4), 64'(r));
		send_frame(1'b0, 12'h000, 1504, -1, r);
		check_value("jumbo result", 64'(5), 64'(r));
		repeat (8) @(posedge fabric_clk);
		check_value("frame_valid", 64'(0), 64'(frame_valid));

		// Aborted frame leaves no trace and the next one is intact
		test_name = "in_drop abort";
		send_frame(1'b0, 12'h000, 100, 10, r);
		check_value("frame_valid", 64'(0), 64'(frame_valid));
		send_frame(1'b0, 12'h000, 72, -1, r);
		check_value("result", 64'(1), 64'(r));
		forward_head();

		// Header plus 46 to 53 covers every last word fill
		test_name = "last word fill";
		for (int len = 46; len < 54; len++) begin
			send_frame(1'b0, 12'h000, len, -1, r);
			check_value("result", 64'(1), 64'(r));
			forward_head();
		end

		// No pops until the buffer overflows and then a drain in order
		test_name = "buffer full";
		r = 0;
		for (int i = 0; i < 60 && r != 2; i++) begin
			send_frame(1'b0, 12'h000, 48 + int'(take_bits(5)), -1, r);
		end
		check_value("fifo drop seen", 64'(2), 64'(r));
		while (exp_q.size() > 0) begin
			forward_head();
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== tests/rx_fifo_sva.sv ====
module rx_fifo_sva
	import eth_pkg::*;
	import rx_buffer_pkg::*;
(
	input logic fabric_clk,
	input logic rst_n,
	input frame_meta_t meta_head,
	input logic frame_valid,
	input logic fwd_en,
	input logic fabric_pop,
	input logic fwd_valid,
	input byte_count_t fwd_bytes
);

	// Stream accepted and not yet finished
	logic busy;
	// Words the running stream still owes
	word_count_t words_left;
	logic more_words;

	//////////////////////////////
	// Stream tracking
	//////////////////////////////

	// Header plus payload in whole 8-byte words
	always_ff @(posedge fabric_clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			words_left <= '0;
		end else if (!busy && frame_valid && fwd_en && !fabric_pop) begin
			busy <= 1'b1;
			words_left <= word_count_t'((meta_head.len + ETH_HEADER_BYTES + 7) / 8);
		end else if (busy && fwd_valid) begin
			busy <= words_left != word_count_t'(1);
			words_left <= words_left - 1'b1;
		end
	end

	// Current word is not the last of its frame
	assign more_words = busy && words_left > word_count_t'(1);

	//////////////////////////////
	// Output stream shape
	//////////////////////////////

	a_contiguous: assert property (@(posedge fabric_clk) disable iff (!rst_n)
		fwd_valid && more_words |=> fwd_valid)
		else $error("fwd_valid gap inside a frame");

	a_full_words: assert property (@(posedge fabric_clk) disable iff (!rst_n)
		fwd_valid && more_words |-> fwd_bytes == 4'd8)
		else $error("short word before the end of a frame");

	// Frame leaves the fabric view right after its pop
	a_pop_drop: assert property (@(posedge fabric_clk) disable iff (!rst_n)
		frame_valid && !busy && fabric_pop |=> !frame_valid)
		else $error("frame_valid still high after pop");

endmodule

bind frame_forwarder rx_fifo_sva u_sva (
	.fabric_clk(fabric_clk),
	.rst_n(rst_n),
	.meta_head(meta_head),
	.frame_valid(frame_valid),
	.fwd_en(fwd_en),
	.fabric_pop(fabric_pop),
	.fwd_valid(fwd_valid),
	.fwd_bytes(fwd_bytes)
);

// ==== source/rx_fifo.sv ====
module rx_fifo
	import eth_pkg::*;
	import rx_buffer_pkg::*;
(
	input logic fabric_clk,
	input logic rst_n,
	// Frame input
	input logic in_start,
	input mac_addr_t in_dst_mac,
	input mac_addr_t in_src_mac,
	input ethertype_t in_ethertype,
	input logic in_has_tag,
	input vlan_id_t in_tag_vlan,
	input logic in_valid,
	input half_word_t in_data,
	input byte_count_t in_bytes,
	input logic in_commit,
	input logic in_drop,
	// VLAN configuration
	input logic has_port_vlan,
	input vlan_id_t port_vlan_id,
	input logic native_vlan_allowed,
	// Event pulses
	output logic q_queued,
	output logic q_drop_fifo,
	output logic q_drop_vlan,
	output logic q_drop_runt,
	output logic q_drop_jumbo,
	// Fabric side
	output logic frame_valid,
	output mac_addr_t frame_dst_mac,
	output mac_addr_t frame_src_mac,
	output vlan_id_t frame_vlan,
	input logic fwd_en,
	output logic fwd_valid,
	output byte_count_t fwd_bytes,
	output fifo_word_t fwd_data,
	input logic fabric_pop
);

	logic meta_push;
	frame_meta_t meta_rec;
	logic meta_not_empty;
	frame_meta_t meta_head;
	logic meta_pop;

	pkt_wr_if wr_bus ();
	pkt_rd_if rd_bus ();

	rx_ingest u_ingest (
		.fabric_clk(fabric_clk),
		.rst_n(rst_n),
		.in_start(in_start),
		.in_dst_mac(in_dst_mac),
		.in_src_mac(in_src_mac),
		.in_ethertype(in_ethertype),
		.in_has_tag(in_has_tag),
		.in_tag_vlan(in_tag_vlan),
		.in_valid(in_valid),
		.in_data(in_data),
		.in_bytes(in_bytes),
		.in_commit(in_commit),
		.in_drop(in_drop),
		.has_port_vlan(has_port_vlan),
		.port_vlan_id(port_vlan_id),
		.native_vlan_allowed(native_vlan_allowed),
		.meta_push(meta_push),
		.meta_rec(meta_rec),
		.q_queued(q_queued),
		.q_drop_fifo(q_drop_fifo),
		.q_drop_vlan(q_drop_vlan),
		.q_drop_runt(q_drop_runt),
		.q_drop_jumbo(q_drop_jumbo),
		.wr(wr_bus.writer)
	);

	packet_fifo u_packet_fifo (
		.fabric_clk(fabric_clk),
		.rst_n(rst_n),
		.wr(wr_bus.memory),
		.rd(rd_bus.memory)
	);

	meta_fifo u_meta_fifo (
		.fabric_clk(fabric_clk),
		.rst_n(rst_n),
		.push(meta_push),
		.push_rec(meta_rec),
		.pop(meta_pop),
		.not_empty(meta_not_empty),
		.head_rec(meta_head)
	);

	frame_forwarder u_forwarder (
		.fabric_clk(fabric_clk),
		.rst_n(rst_n),
		.meta_not_empty(meta_not_empty),
		.meta_head(meta_head),
		.fwd_en(fwd_en),
		.fabric_pop(fabric_pop),
		.meta_pop(meta_pop),
		.frame_valid(frame_valid),
		.frame_dst_mac(frame_dst_mac),
		.frame_src_mac(frame_src_mac),
		.frame_vlan(frame_vlan),
		.fwd_valid(fwd_valid),
		.fwd_bytes(fwd_bytes),
		.fwd_data(fwd_data),
		.rd(rd_bus.writer)
	);

endmodule

// ==== source/frame_forwarder.sv ====
module frame_forwarder
	import eth_pkg::*;
	import rx_buffer_pkg::*;
(
	input logic fabric_clk,
	input logic rst_n,
	input logic meta_not_empty,
	input frame_meta_t meta_head,
	input logic fwd_en,
	input logic fabric_pop,
	output logic meta_pop,
	// Head frame offered to the fabric
	output logic frame_valid,
	output mac_addr_t frame_dst_mac,
	output mac_addr_t frame_src_mac,
	output vlan_id_t frame_vlan,
	// Rebuilt frame stream
	output logic fwd_valid,
	output byte_count_t fwd_bytes,
	output fifo_word_t fwd_data,
	pkt_rd_if.writer rd
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_LOAD,
		S_STREAM
	} fwd_state_t;

	fwd_state_t state;
	// Stream step, word k goes out at step k+1
	word_count_t seq;
	word_count_t last_seq;
	frame_len_t total_bytes;
	byte_count_t last_bytes;
	fifo_word_t prev_word;
	fifo_word_t next_word;
	fifo_word_t keep_mask;
	logic fwd_ok;
	logic pop_ok;

	// Requests only count while a frame is held and no stream runs, pop wins a tie
	assign pop_ok = frame_valid && state == S_IDLE && fabric_pop;
	assign fwd_ok = frame_valid && state == S_IDLE && fwd_en && !fabric_pop;

	//////////////////////////////
	// Frame geometry
	//////////////////////////////

	assign total_bytes = meta_head.len + frame_len_t'(ETH_HEADER_BYTES);
	assign last_seq = word_count_t'((total_bytes + 11'd7) >> 3);
	// 1 to 8 bytes in the final word
	assign last_bytes = {1'b0, 3'(total_bytes[2:0] - 3'd1)} + 4'd1;
	assign keep_mask = ~({64{1'b1}} >> {last_bytes, 3'b000});

	// Payload read one step ahead of the word that needs it
	assign rd.rd_en = state == S_STREAM && seq != '0;
	assign rd.rd_offset = DATA_ADDR_BITS'(seq - 1'b1);
	// Free the payload rounded up to whole lines
	assign rd.pop = pop_ok;
	assign rd.pkt_words = word_count_t'((meta_head.len + 11'd7) >> 3);
	assign meta_pop = pop_ok;

	// Header first, then payload shifted by the 2 ethertype bytes
	always_comb begin
		if (seq == word_count_t'(1)) begin
			next_word = {meta_head.dst_mac, meta_head.src_mac[47:32]};
		end else if (seq == word_count_t'(2)) begin
			next_word = {meta_head.src_mac[31:0], meta_head.ethertype, rd.rd_data[63:48]};
		end else begin
			next_word = {prev_word[47:0], rd.rd_data[63:48]};
		end
	end

	//////////////////////////////
	// Control FSM
	//////////////////////////////

	always_ff @(posedge fabric_clk) begin
		if (!rst_n) begin
			state <= S_IDLE;
			seq <= '0;
			frame_valid <= 1'b0;
			fwd_valid <= 1'b0;
		end else begin
			fwd_valid <= 1'b0;
			case (state)
				S_IDLE: begin
					if (!frame_valid && meta_not_empty) begin
						state <= S_LOAD;
					end else if (fwd_ok) begin
						state <= S_STREAM;
						seq <= '0;
					end
					if (pop_ok) begin
						frame_valid <= 1'b0;
					end
				end
				// Head record is registered, offer it next cycle
				S_LOAD: begin
					frame_valid <= 1'b1;
					state <= S_IDLE;
				end
				S_STREAM: begin
					seq <= seq + 1'b1;
					if (seq != '0) begin
						fwd_valid <= 1'b1;
						if (seq == last_seq) begin
							state <= S_IDLE;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Output data
	//////////////////////////////

	always_ff @(posedge fabric_clk) begin
		if (state == S_LOAD) begin
			frame_dst_mac <= meta_head.dst_mac;
			frame_src_mac <= meta_head.src_mac;
			frame_vlan <= meta_head.vlan;
		end
		prev_word <= rd.rd_data;
		if (state == S_STREAM && seq != '0) begin
			// Unused low bytes of the last word are zero
			if (seq == last_seq) begin
				fwd_data <= next_word & keep_mask;
				fwd_bytes <= last_bytes;
			end else begin
				fwd_data <= next_word;
				fwd_bytes <= 4'd8;
			end
		end
	end

endmodule

// ==== source/meta_fifo.sv ====
module meta_fifo
	import rx_buffer_pkg::*;
(
	input logic fabric_clk,
	input logic rst_n,
	input logic push,
	input frame_meta_t push_rec,
	input logic pop,
	output logic not_empty,
	output frame_meta_t head_rec
);

	frame_meta_t mem [META_DEPTH];

	logic [META_ADDR_BITS:0] wr_ptr;
	logic [META_ADDR_BITS:0] rd_ptr;
	logic [META_ADDR_BITS:0] wr_next;
	logic [META_ADDR_BITS:0] rd_next;

	// Pop of an empty FIFO is ignored
	assign wr_next = wr_ptr + (META_ADDR_BITS + 1)'(push);
	assign rd_next = rd_ptr + (META_ADDR_BITS + 1)'(pop && not_empty);

	always_ff @(posedge fabric_clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			not_empty <= 1'b0;
		end else begin
			wr_ptr <= wr_next;
			rd_ptr <= rd_next;
			not_empty <= wr_next != rd_next;
		end
	end

	always_ff @(posedge fabric_clk) begin
		if (push) begin
			mem[wr_ptr[META_ADDR_BITS-1:0]] <= push_rec;
		end
		// Bypass when the new head is the record being written
		if (push && rd_next == wr_ptr) begin
			head_rec <= push_rec;
		end else begin
			head_rec <= mem[rd_next[META_ADDR_BITS-1:0]];
		end
	end

endmodule

// ==== source/packet_fifo.sv ====
module packet_fifo
	import rx_buffer_pkg::*;
(
	input logic fabric_clk,
	input logic rst_n,
	pkt_wr_if.memory wr,
	pkt_rd_if.memory rd
);

	fifo_word_t mem [DATA_DEPTH];

	// Extra top bit tells a full buffer from an empty one
	logic [DATA_ADDR_BITS:0] wr_ptr;
	logic [DATA_ADDR_BITS:0] commit_ptr;
	logic [DATA_ADDR_BITS:0] rd_ptr;
	logic [DATA_ADDR_BITS:0] used_words;
	logic [DATA_ADDR_BITS-1:0] rd_addr;

	//////////////////////////////
	// Occupancy
	//////////////////////////////

	// Counted against the tentative pointer so an open frame sees its own words
	assign used_words = wr_ptr - rd_ptr;
	assign wr.free_words = word_count_t'(DATA_DEPTH) - word_count_t'(used_words);

	// Reads are relative to the head packet and wrap around the memory
	assign rd_addr = rd_ptr[DATA_ADDR_BITS-1:0] + rd.rd_offset;

	always_ff @(posedge fabric_clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			commit_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			// Rollback discards everything since the last commit
			if (wr.rollback) begin
				wr_ptr <= commit_ptr;
			end else if (wr.wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (wr.commit) begin
				commit_ptr <= wr_ptr;
			end
			// Whole packet leaves at once
			if (rd.pop) begin
				rd_ptr <= rd_ptr + rd.pkt_words;
			end
		end
	end

	//////////////////////////////
	// Storage
	//////////////////////////////

	always_ff @(posedge fabric_clk) begin
		if (wr.wr_en) begin
			mem[wr_ptr[DATA_ADDR_BITS-1:0]] <= wr.wr_data;
		end
		// Nondestructive read, one cycle latency
		if (rd.rd_en) begin
			rd.rd_data <= mem[rd_addr];
		end
	end

endmodule

// ==== source/rx_ingest.sv ====
module rx_ingest
	import eth_pkg::*;
	import rx_buffer_pkg::*;
(
	input logic fabric_clk,
	input logic rst_n,
	// Parsed frame from the MAC side
	input logic in_start,
	input mac_addr_t in_dst_mac,
	input mac_addr_t in_src_mac,
	input ethertype_t in_ethertype,
	input logic in_has_tag,
	input vlan_id_t in_tag_vlan,
	input logic in_valid,
	input half_word_t in_data,
	input byte_count_t in_bytes,
	input logic in_commit,
	input logic in_drop,
	// Port VLAN policy
	input logic has_port_vlan,
	input vlan_id_t port_vlan_id,
	input logic native_vlan_allowed,
	// Header record towards the metadata FIFO
	output logic meta_push,
	output frame_meta_t meta_rec,
	// Event pulses
	output logic q_queued,
	output logic q_drop_fifo,
	output logic q_drop_vlan,
	output logic q_drop_runt,
	output logic q_drop_jumbo,
	pkt_wr_if.writer wr
);

	// Frame accepted so far and still being received
	logic frame_open;
	// Upper half of the next 64-bit word is held
	logic half_valid;
	half_word_t half_data;
	half_word_t low_half;
	// Commit waits one cycle for the last half word
	logic flush_pend;
	frame_len_t len_next;
	logic vlan_reject;
	vlan_id_t vlan_pick;

	//////////////////////////////
	// VLAN policy
	//////////////////////////////

	always_comb begin
		vlan_pick = port_vlan_id;
		if (in_has_tag) begin
			// Tagged traffic on a port VLAN only with native mode, blocks VLAN hopping
			vlan_pick = in_tag_vlan;
			vlan_reject = has_port_vlan && !native_vlan_allowed;
		end else begin
			// Trunk only, untagged frames have no VLAN to join
			vlan_reject = !has_port_vlan;
		end
	end

	assign len_next = meta_rec.len + frame_len_t'(in_bytes);
	// Flush pads the missing low half with zeros
	assign low_half = in_valid ? in_data : '0;

	//////////////////////////////
	// Frame control
	//////////////////////////////

	always_ff @(posedge fabric_clk) begin
		if (!rst_n) begin
			frame_open <= 1'b0;
			half_valid <= 1'b0;
			flush_pend <= 1'b0;
			wr.wr_en <= 1'b0;
			wr.commit <= 1'b0;
			wr.rollback <= 1'b0;
			meta_push <= 1'b0;
			q_queued <= 1'b0;
			q_drop_fifo <= 1'b0;
			q_drop_vlan <= 1'b0;
			q_drop_runt <= 1'b0;
			q_drop_jumbo <= 1'b0;
		end else begin
			// Strobes and pulses last one cycle
			wr.wr_en <= 1'b0;
			wr.commit <= 1'b0;
			wr.rollback <= 1'b0;
			meta_push <= 1'b0;
			q_queued <= 1'b0;
			q_drop_fifo <= 1'b0;
			q_drop_vlan <= 1'b0;
			q_drop_runt <= 1'b0;
			q_drop_jumbo <= 1'b0;
			flush_pend <= 1'b0;

			// Delayed commit once the padded half word is written
			if (flush_pend) begin
				wr.commit <= 1'b1;
				meta_push <= 1'b1;
				q_queued <= 1'b1;
			end

			if (in_drop) begin
				// MAC abort, silent rollback
				frame_open <= 1'b0;
				half_valid <= 1'b0;
				wr.rollback <= 1'b1;
			end else if (in_start) begin
				half_valid <= 1'b0;
				frame_open <= !vlan_reject;
				q_drop_vlan <= vlan_reject;
			end else if (frame_open) begin
				if (in_commit) begin
					frame_open <= 1'b0;
					half_valid <= 1'b0;
					if (meta_rec.len < frame_len_t'(MIN_PAYLOAD_BYTES)) begin
						wr.rollback <= 1'b1;
						q_drop_runt <= 1'b1;
					end else if (half_valid) begin
						wr.wr_en <= 1'b1;
						flush_pend <= 1'b1;
					end else begin
						wr.commit <= 1'b1;
						meta_push <= 1'b1;
						q_queued <= 1'b1;
					end
				end else if (wr.free_words < word_count_t'(2)) begin
					// Out of buffer midway through the frame
					frame_open <= 1'b0;
					half_valid <= 1'b0;
					wr.rollback <= 1'b1;
					q_drop_fifo <= 1'b1;
				end else if (in_valid) begin
					if (len_next > frame_len_t'(MAX_PAYLOAD_BYTES)) begin
						frame_open <= 1'b0;
						half_valid <= 1'b0;
						wr.rollback <= 1'b1;
						q_drop_jumbo <= 1'b1;
					end else begin
						// Every second word completes a line
						half_valid <= !half_valid;
						wr.wr_en <= half_valid;
					end
				end
			end
		end
	end

	//////////////////////////////
	// Header and word packing
	//////////////////////////////

	always_ff @(posedge fabric_clk) begin
		if (in_start) begin
			meta_rec.len <= '0;
			meta_rec.dst_mac <= in_dst_mac;
			meta_rec.src_mac <= in_src_mac;
			meta_rec.ethertype <= in_ethertype;
			meta_rec.vlan <= vlan_pick;
		end else if (frame_open && in_valid) begin
			meta_rec.len <= len_next;
		end
		// Earlier word lands in the upper half
		if (in_valid && !half_valid) begin
			half_data <= in_data;
		end
		if (half_valid) begin
			wr.wr_data <= {half_data, low_half};
		end
	end

endmodule

// ==== source/packet_fifo_if.sv ====
// Write side of the packet FIFO
interface pkt_wr_if
	import rx_buffer_pkg::*;
();

	logic wr_en;
	fifo_word_t wr_data;
	logic commit;
	logic rollback;
	// Space left behind the tentative write pointer
	word_count_t free_words;

	modport writer(output wr_en, wr_data, commit, rollback, input free_words);
	modport memory(input wr_en, wr_data, commit, rollback, output free_words);

endinterface

// Read side, offset reads plus whole packet pop
interface pkt_rd_if
	import rx_buffer_pkg::*;
();

	logic rd_en;
	logic [DATA_ADDR_BITS-1:0] rd_offset;
	logic pop;
	word_count_t pkt_words;
	fifo_word_t rd_data;

	modport writer(output rd_en, rd_offset, pop, pkt_words, input rd_data);
	modport memory(input rd_en, rd_offset, pop, pkt_words, output rd_data);

endinterface

// ==== source/rx_buffer_pkg.sv ====
package rx_buffer_pkg;

	import eth_pkg::*;

	//////////////////////////////
	// Buffer geometry
	//////////////////////////////

	// Payload memory, 64-bit lines
	localparam int DATA_DEPTH = 256;
	localparam int DATA_ADDR_BITS = 8;

	// One record per frame, enough for a full buffer of minimum frames
	localparam int META_DEPTH = 64;
	localparam int META_ADDR_BITS = 6;

	//////////////////////////////
	// Word and count types
	//////////////////////////////

	typedef logic [31:0] half_word_t;
	typedef logic [63:0] fifo_word_t;
	// Payload length in bytes
	typedef logic [10:0] frame_len_t;
	// Wide enough to hold DATA_DEPTH itself
	typedef logic [8:0] word_count_t;
	// Valid bytes in one word, 1 to 8
	typedef logic [3:0] byte_count_t;

	// Header record stored beside each frame
	typedef struct packed {
		frame_len_t len;
		mac_addr_t dst_mac;
		mac_addr_t src_mac;
		ethertype_t ethertype;
		vlan_id_t vlan;
	} frame_meta_t;

endpackage

// ==== source/eth_pkg.sv ====
package eth_pkg;

	//////////////////////////////
	// Frame field types
	//////////////////////////////

	// Station address, first byte on the wire in the top bits
	typedef logic [47:0] mac_addr_t;

	// Protocol type following the addresses
	typedef logic [15:0] ethertype_t;

	// 802.1Q VLAN number
	typedef logic [11:0] vlan_id_t;

	//////////////////////////////
	// Length limits
	//////////////////////////////

	// Shortest legal payload, anything below is a runt
	localparam int MIN_PAYLOAD_BYTES = 46;
	// Longest payload before a frame counts as oversized
	localparam int MAX_PAYLOAD_BYTES = 1500;
	// Rebuilt untagged header, destination plus source plus ethertype
	localparam int ETH_HEADER_BYTES = 14;

endpackage
